// ==== sources.f ====
source/hires_pkg.sv
source/hires_phase_gen.sv
source/hires_video_ram.sv
source/hires_fetch_unit.sv
source/hires_pixel_sequencer.sv
source/hires_video_top.sv
verification/tb_hires_clock.sv
verification/tb_hires_video.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the hires video testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_hires_video \
    -f sources.f \
    -o tb_hires_video_sim

./obj_dir/tb_hires_video_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
if ! grep -q "Test passed" sim.log; then
    exit 1
fi
exit 0

// ==== verification/tb_hires_video.sv ====
`timescale 1ns/10ps

module tb_hires_video import hires_pkg::*; ();

    localparam logic [31:0] lfsr_seed = 32'h68da_fe31;
    localparam logic [31:0] lfsr_taps = 32'h8020_0003;
    localparam int line_ticks = cycles_per_line * 32;
    localparam int frame_timeout = 2 * lines_per_frame * line_ticks;

    logic       clk_dot4x;
    logic       arst_n;
    logic       wr_valid;
    logic       wr_ready;
    logic       wr_plane;
    logic [9:0] wr_addr;
    logic [7:0] wr_data;
    logic [1:0] hires_mode;
    logic [2:0] xscroll;
    logic [3:0] b0c;
    logic [3:0] ec;
    logic [3:0] color_base;
    logic [9:0] cursor_addr;
    logic [3:0] pixel_color;
    logic       pixel_strobe;
    logic       is_background;
    logic       line_start;

    // current picture content, constant over every checked frame
    logic [7:0]  cur_pix;
    logic [7:0]  cur_attr;
    logic [31:0] lfsr;
    logic        check_en;
    int          line_idx;
    int          blink_count;
    int          value_errors;
    int          timeout_errors;

    tb_hires_clock i_clock (
        .clk_dot4x (clk_dot4x),
        .arst_n    (arst_n)
    );

    hires_video_top i_dut (
        .clk_dot4x     (clk_dot4x),
        .arst_n        (arst_n),
        .wr_valid      (wr_valid),
        .wr_ready      (wr_ready),
        .wr_plane      (wr_plane),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .hires_mode    (hires_mode),
        .xscroll       (xscroll),
        .b0c           (b0c),
        .ec            (ec),
        .color_base    (color_base),
        .cursor_addr   (cursor_addr),
        .pixel_color   (pixel_color),
        .pixel_strobe  (pixel_strobe),
        .is_background (is_background),
        .line_start    (line_start)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ lfsr_taps) : (state >> 1);
    endfunction

    task automatic random_bits(input int width, output logic [7:0] value);
        value = '0;
        for (int i = 0; i < width; i++) begin
            lfsr = lfsr_step(lfsr);
            value = {value[6:0], lfsr[0]};
        end
    endtask

    // k is the half-dot strobe within one phi cycle, 0 to 15
    function automatic logic [3:0] expected_color(input int k, input logic [1:0] mode,
                                                  input logic [7:0] pix, input logic [7:0] attr,
                                                  input logic [2:0] rc, input logic blink_on);
        logic [15:0] pair;
        logic        bit_val;
        logic        shown;
        int          m;
        pair = {attr, pix};
        m = k % 8;
        bit_val = pix[7 - m];
        case (mode)
            mode_text: begin
                shown = (!attr[attr_blnk_bit] || blink_on) &&
                        ((attr[attr_undr_bit] && rc == 3'd7) || (bit_val ^ attr[attr_rvrs_bit]));
                return shown ? attr[3:0] : b0c;
            end
            mode_bitmap: return bit_val ? attr[3:0] : b0c;
            // each nibble is held for two strobes
            mode_packed16: return pair[15 - 4 * (m / 2) -: 4];
            default: return {color_base[1:0], pair[15 - 2 * m -: 2]};
        endcase
    endfunction

    function automatic logic expected_background(input int k, input logic [1:0] mode,
                                                 input logic [3:0] color, input logic [7:0] pix);
        if (mode == mode_text || mode == mode_bitmap) begin
            return !pix[7 - (k % 8)];
        end
        return color == b0c;
    endfunction

    task automatic check_value(input int actual, input int expected, input string what);
        if (actual != expected) begin
            value_errors++;
            $display("FAIL %0t: %s is %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        timeout_errors++;
        $display("timed out while waiting for %s", what);
        $display("errors: %0d value, %0d timeout", value_errors, timeout_errors);
        $display("Test failed");
        $finish;
    endtask

    // color histogram per raster line, compared when the next line starts
    always @(posedge clk_dot4x) begin : line_checker
        int         hist [16];
        int         exp_hist [16];
        int         bg_seen;
        int         bg_exp;
        logic       line_active;
        logic [3:0] c;
        logic [2:0] rc;
        if (pixel_strobe) begin
            hist[pixel_color]++;
            bg_seen += is_background;
        end
        if (line_start) begin
            if (line_active) begin
                foreach (exp_hist[i]) exp_hist[i] = 0;
                bg_exp = 0;
                if (line_idx < first_visible_line || line_idx > last_visible_line) begin
                    exp_hist[ec] = cycles_per_line * 16;
                end else begin
                    rc = 3'(line_idx - first_visible_line);
                    exp_hist[ec] = (cycles_per_line - cols_per_row) * 16;
                    for (int k = 0; k < 16; k++) begin
                        c = expected_color(k, hires_mode, cur_pix, cur_attr, rc,
                                           blink_count[blink_freq_bit]);
                        exp_hist[c] += cols_per_row;
                        bg_exp += cols_per_row *
                                  int'(expected_background(k, hires_mode, c, cur_pix));
                    end
                end
                for (int i = 0; i < 16; i++) begin
                    check_value(hist[i], exp_hist[i],
                                $sformatf("line %0d count of color %0h", line_idx, i));
                end
                check_value(bg_seen, bg_exp, $sformatf("line %0d background count", line_idx));
            end
            foreach (hist[i]) hist[i] = 0;
            bg_seen = 0;
            line_active = check_en;
            line_idx <= (line_idx + 1) % lines_per_frame;
            if ((line_idx + 1) % lines_per_frame == 0) begin
                blink_count <= blink_count + 1;
            end
        end
    end

    task automatic wait_line(input int target);
        int n;
        n = 0;
        do begin
            @(posedge clk_dot4x);
            n++;
        end while (!(line_start && (line_idx + 1) % lines_per_frame == target) &&
                   n < frame_timeout);
        if (n >= frame_timeout) stop_on_timeout($sformatf("start of line %0d", target));
    endtask

    // host writes, one per edge while ready stays high
    task automatic write_byte(input logic plane, input logic [9:0] addr, input logic [7:0] data);
        int n;
        n = 0;
        wr_valid <= 1'b1;
        wr_plane <= plane;
        wr_addr <= addr;
        wr_data <= data;
        do begin
            @(posedge clk_dot4x);
            n++;
            check_value(wr_ready, 1, "wr_ready");
        end while (!wr_ready && n < 64);
        if (n >= 64) stop_on_timeout("wr_ready");
    endtask

    task automatic fill_ram(input logic [7:0] pix, input logic [7:0] attr);
        @(posedge clk_dot4x);
        for (int a = 0; a < ram_depth; a++) begin
            write_byte(1'b0, 10'(a), pix);
            write_byte(1'b1, 10'(a), attr);
        end
        wr_valid <= 1'b0;
        cur_pix = pix;
        cur_attr = attr;
    endtask

    // enable on a line 11 start so checking covers whole frames
    task automatic run_frames(input int n);
        wait_line(lines_per_frame - 1);
        check_en <= 1'b1;
        repeat (n) wait_line(lines_per_frame - 1);
        check_en <= 1'b0;
        wait_line(0);
    endtask

    initial begin : stimulus
        logic [7:0] c;
        logic [7:0] r;
        int         n;
        wr_valid = 1'b0;
        wr_plane = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        hires_mode = mode_bitmap;
        xscroll = '0;
        b0c = 4'h6;
        ec = 4'h2;
        color_base = '0;
        cursor_addr = 10'd500;
        check_en = 1'b0;
        lfsr = lfsr_seed;
        line_idx = lines_per_frame - 1;
        blink_count = 0;
        value_errors = 0;
        timeout_errors = 0;
        cur_pix = '0;
        cur_attr = '0;

        n = 0;
        while (!arst_n && n < 16) begin
            @(posedge clk_dot4x);
            n++;
            check_value(pixel_strobe, 0, "pixel_strobe in reset");
            check_value(line_start, 0, "line_start in reset");
        end
        if (n >= 16) stop_on_timeout("reset release");
        n = 0;
        do begin
            @(posedge clk_dot4x);
            n++;
        end while (!pixel_strobe && n < 16);
        if (n >= 16) stop_on_timeout("first pixel strobe");

        // attribute color distinct from ec and b0c
        do random_bits(4, c); while (c[3:0] == ec || c[3:0] == b0c);

        fill_ram(8'hff, {4'h0, c[3:0]});
        run_frames(1);
        fill_ram(8'h00, {4'h0, c[3:0]});
        run_frames(1);

        hires_mode <= mode_text;
        fill_ram(8'h00, 8'(1 << attr_rvrs_bit) | {4'h0, c[3:0]});
        run_frames(1);
        fill_ram(8'h00, 8'(1 << attr_undr_bit) | {4'h0, c[3:0]});
        run_frames(1);

        hires_mode <= mode_packed16;
        random_bits(8, r);
        random_bits(8, c);
        fill_ram(r, c);
        run_frames(1);
        hires_mode <= mode_packed4;
        random_bits(4, c);
        color_base <= c[3:0];
        random_bits(8, r);
        random_bits(8, c);
        fill_ram(r, c);
        run_frames(1);

        // blink spans the frames where counter bit 5 turns on
        hires_mode <= mode_text;
        do random_bits(4, c); while (c[3:0] == ec || c[3:0] == b0c);
        fill_ram(8'h00, 8'((1 << attr_blnk_bit) | (1 << attr_rvrs_bit)) | {4'h0, c[3:0]});
        run_frames(35 - blink_count);

        $display("errors: %0d value, %0d timeout", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== verification/tb_hires_clock.sv ====
`timescale 1ns/10ps

module tb_hires_clock (
    output logic clk_dot4x,
    output logic arst_n
);

    localparam time half_period = 20ns;

    initial begin
        clk_dot4x = 1'b0;
        forever #(half_period) clk_dot4x = ~clk_dot4x;
    end

    // reset held low for the first two clock cycles
    initial begin
        arst_n = 1'b0;
        repeat (2) @(posedge clk_dot4x);
        arst_n <= 1'b1;
    end

endmodule

// ==== source/hires_video_top.sv ====
`timescale 1ns/10ps

module hires_video_top import hires_pkg::*; (
    input  logic       clk_dot4x,
    input  logic       arst_n,
    input  logic       wr_valid,
    output logic       wr_ready,
    input  logic       wr_plane,
    input  logic [9:0] wr_addr,
    input  logic [7:0] wr_data,
    input  logic [1:0] hires_mode,
    input  logic [2:0] xscroll,
    input  logic [3:0] b0c,
    input  logic [3:0] ec,
    input  logic [3:0] color_base,
    input  logic [9:0] cursor_addr,
    output logic [3:0] pixel_color,
    output logic       pixel_strobe,
    output logic       is_background,
    output logic       line_start
);

    timing_if      tim ();
    hires_fetch_if fetch ();

    logic        wr_en;
    logic [9:0]  rd_addr;
    logic [7:0]  rd_pixel;
    hires_attr_u rd_color;

    // the RAM has a separate read port, so host writes never wait
    assign wr_ready = 1'b1;
    assign wr_en = wr_valid && wr_ready;
    assign line_start = tim.phase_start_dav && (tim.cycle_num == 7'd0);

    hires_phase_gen i_phase_gen (
        .clk_dot4x (clk_dot4x),
        .arst_n    (arst_n),
        .tim       (tim.gen)
    );

    hires_video_ram i_video_ram (
        .clk_dot4x (clk_dot4x),
        .wr_en     (wr_en),
        .wr_plane  (wr_plane),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_addr   (rd_addr),
        .rd_pixel  (rd_pixel),
        .rd_color  (rd_color)
    );

    hires_fetch_unit i_fetch_unit (
        .clk_dot4x   (clk_dot4x),
        .arst_n      (arst_n),
        .tim         (tim.sink),
        .cursor_addr (cursor_addr),
        .rd_addr     (rd_addr),
        .rd_pixel    (rd_pixel),
        .rd_color    (rd_color),
        .fetch       (fetch.src)
    );

    hires_pixel_sequencer i_pixel_sequencer (
        .clk_dot4x     (clk_dot4x),
        .arst_n        (arst_n),
        .tim           (tim.sink),
        .fetch         (fetch.dst),
        .xscroll       (xscroll),
        .b0c           (b0c),
        .ec            (ec),
        .color_base    (color_base),
        .hires_mode    (hires_mode),
        .pixel_color   (pixel_color),
        .pixel_strobe  (pixel_strobe),
        .is_background (is_background)
    );

endmodule

// ==== source/hires_pixel_sequencer.sv ====
`timescale 1ns/10ps

module hires_pixel_sequencer import hires_pkg::*; (
    input  logic       clk_dot4x,
    input  logic       arst_n,
    timing_if.sink     tim,
    hires_fetch_if.dst fetch,
    input  logic [2:0] xscroll,
    input  logic [3:0] b0c,
    input  logic [3:0] ec,
    input  logic [3:0] color_base,
    input  logic [1:0] hires_mode,
    output logic [3:0] pixel_color,
    output logic       pixel_strobe,
    output logic       is_background
);

    logic [2:0] xscroll_d0;
    logic [2:0] xscroll_delayed;

    // bytes travel through the delay line on phase_start_10
    logic [7:0]  pixel_dly [seq_delay_stages];
    hires_attr_u color_dly [seq_delay_stages];
    logic [seq_delay_stages-1:0] cursor_dly;

    // pl stage, ready for the shifter loads of the next strobes
    logic [7:0]  pixel_pl;
    hires_attr_u color_pl;
    logic        cursor_pl;

    logic [7:0]  pix_shift;
    logic [7:0]  pix_next;
    hires_attr_u color_shift;
    hires_attr_u color_next;
    logic        cursor_shift;
    logic        cursor_next;
    logic [15:0] pair_shift;
    logic [15:0] pair_next;

    logic       shift_tick;
    logic       load;
    logic       visible;
    logic       hires_stage0;
    logic       hires_ff;
    logic       border_stage0;
    logic       pixel_value;
    logic [3:0] pair_value;
    logic [3:0] b0c_stage0;
    logic [3:0] ec_stage0;
    logic       blink_ok;
    logic       text_on;
    logic [3:0] packed4_color;

    assign shift_tick = tim.dot_rising[1] || tim.dot_rising[3];
    assign load = shift_tick && (xscroll_delayed == tim.hires_cycle_bit);
    assign visible = !tim.main_border && !tim.vborder;

    always_ff @(posedge clk_dot4x or negedge arst_n) begin
        if (!arst_n) begin
            xscroll_d0 <= '0;
            xscroll_delayed <= '0;
        end else begin
            if (tim.phase_start_dav) begin
                xscroll_d0 <= xscroll;
            end
            // pl opens the high half of phi
            if (tim.phase_start_pl && tim.clk_phi && visible) begin
                xscroll_delayed <= xscroll_d0;
            end
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (tim.phase_start_10) begin
            pixel_dly[0] <= fetch.pixel_data;
            color_dly[0] <= fetch.color_data;
            cursor_dly <= {cursor_dly[seq_delay_stages-2:0], fetch.cursor};
            for (int i = 1; i < seq_delay_stages; i++) begin
                pixel_dly[i] <= pixel_dly[i-1];
                color_dly[i] <= color_dly[i-1];
            end
        end
        if (tim.phase_start_pl) begin
            pixel_pl <= pixel_dly[seq_delay_stages-1];
            color_pl <= color_dly[seq_delay_stages-1];
            cursor_pl <= cursor_dly[seq_delay_stages-1];
        end
    end

    // outside the window the shifters are loaded with zeros
    always_comb begin
        pix_next = pix_shift;
        color_next = color_shift;
        cursor_next = cursor_shift;
        pair_next = pair_shift;
        if (load) begin
            if (visible) begin
                pix_next = pixel_pl;
                color_next = color_pl;
                cursor_next = cursor_pl;
                pair_next = {color_pl.pair_hi, pixel_pl};
            end else begin
                pix_next = '0;
                color_next = '0;
                cursor_next = 1'b0;
                pair_next = '0;
            end
        end
    end

    always_ff @(posedge clk_dot4x or negedge arst_n) begin
        if (!arst_n) begin
            hires_stage0 <= 1'b0;
            hires_ff <= 1'b0;
            pixel_strobe <= 1'b0;
        end else begin
            hires_stage0 <= shift_tick;
            pixel_strobe <= hires_stage0;
            // packed16 takes a new nibble on every other strobe after a load
            if (load) begin
                hires_ff <= 1'b1;
            end else if (shift_tick) begin
                hires_ff <= ~hires_ff;
            end
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (shift_tick) begin
            border_stage0 <= tim.main_border || tim.vborder;
            b0c_stage0 <= b0c;
            ec_stage0 <= ec;
            color_shift <= color_next;
            cursor_shift <= cursor_next;
            pixel_value <= pix_next[7];
            pix_shift <= {pix_next[6:0], 1'b0};
            pair_value <= pair_next[15:12];
            pair_shift <= {pair_next[13:0], 2'b00};
        end
    end

    assign blink_ok = !color_shift.attr.flags[attr_blnk_bit] || fetch.blink_ctr[blink_freq_bit];
    assign text_on = blink_ok &&
                     ((color_shift.attr.flags[attr_undr_bit] && fetch.rc == 3'd7) ||
                      (pixel_value ^ (color_shift.attr.flags[attr_rvrs_bit] | cursor_shift)));
    assign packed4_color = {color_base[1:0], pair_value[3:2]};

    always_ff @(posedge clk_dot4x) begin
        if (hires_stage0) begin
            if (border_stage0) begin
                pixel_color <= ec_stage0;
                is_background <= 1'b0;
            end else begin
                case (hires_mode)
                    mode_text: begin
                        pixel_color <= text_on ? color_shift.attr.color : b0c_stage0;
                        is_background <= !pixel_value;
                    end
                    mode_bitmap: begin
                        pixel_color <= pixel_value ? color_shift.attr.color : b0c_stage0;
                        is_background <= !pixel_value;
                    end
                    mode_packed16: begin
                        if (hires_ff) begin
                            pixel_color <= pair_value;
                            is_background <= (pair_value == b0c_stage0);
                        end
                    end
                    mode_packed4: begin
                        pixel_color <= packed4_color;
                        is_background <= (packed4_color == b0c_stage0);
                    end
                endcase
            end
        end
    end

endmodule

// ==== source/hires_fetch_unit.sv ====
`timescale 1ns/10ps

interface hires_fetch_if import hires_pkg::*; ();
    logic [7:0]  pixel_data;
    hires_attr_u color_data;
    logic        cursor;
    logic [2:0]  rc;
    logic [5:0]  blink_ctr;

    modport src (output pixel_data, color_data, cursor, rc, blink_ctr);
    modport dst (input pixel_data, color_data, cursor, rc, blink_ctr);
endinterface

module hires_fetch_unit import hires_pkg::*; (
    input  logic        clk_dot4x,
    input  logic        arst_n,
    timing_if.sink      tim,
    input  logic [9:0]  cursor_addr,
    output logic [9:0]  rd_addr,
    input  logic [7:0]  rd_pixel,
    input  hires_attr_u rd_color,
    hires_fetch_if.src  fetch
);

    logic       line_start;
    logic       rd_pending;
    logic       rd_valid;
    logic [9:0] row_base;

    assign line_start = tim.phase_start_dav && (tim.cycle_num == 7'd0);

    // one cell per phi cycle, addressed from the row base
    always_ff @(posedge clk_dot4x) begin
        if (tim.phase_start_dav) begin
            rd_addr <= row_base + 10'(tim.cycle_num) - 10'(first_visible_cycle);
        end
    end

    // address at dav, RAM output two ticks later
    always_ff @(posedge clk_dot4x or negedge arst_n) begin
        if (!arst_n) begin
            rd_pending <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            rd_pending <= tim.phase_start_dav;
            rd_valid <= rd_pending;
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rd_valid) begin
            fetch.pixel_data <= rd_pixel;
            fetch.color_data <= rd_color;
            fetch.cursor <= (rd_addr == cursor_addr);
        end
    end

    // character row tracking and frame blink count
    always_ff @(posedge clk_dot4x or negedge arst_n) begin
        if (!arst_n) begin
            row_base <= '0;
            fetch.rc <= '0;
            fetch.blink_ctr <= '0;
        end else if (line_start) begin
            fetch.rc <= 3'(tim.raster_line - 4'(first_visible_line));
            if (tim.raster_line == 4'(first_visible_line)) begin
                row_base <= '0;
            end else if (fetch.rc == 3'd7) begin
                // old rc still holds the previous line here
                row_base <= row_base + 10'(cols_per_row);
            end
            if (tim.raster_line == 4'd0) begin
                fetch.blink_ctr <= fetch.blink_ctr + 6'd1;
            end
        end
    end

endmodule

// ==== source/hires_video_ram.sv ====
`timescale 1ns/10ps

module hires_video_ram import hires_pkg::*; (
    input  logic        clk_dot4x,
    input  logic        wr_en,
    input  logic        wr_plane,
    input  logic [9:0]  wr_addr,
    input  logic [7:0]  wr_data,
    input  logic [9:0]  rd_addr,
    output logic [7:0]  rd_pixel,
    output hires_attr_u rd_color
);

    // plane 0 holds pixel bytes, plane 1 attribute bytes
    logic [7:0] pixel_mem [ram_depth];
    logic [7:0] attr_mem [ram_depth];

    always_ff @(posedge clk_dot4x) begin
        if (wr_en && !wr_plane) begin
            pixel_mem[wr_addr] <= wr_data;
        end
        rd_pixel <= pixel_mem[rd_addr];
    end

    always_ff @(posedge clk_dot4x) begin
        if (wr_en && wr_plane) begin
            attr_mem[wr_addr] <= wr_data;
        end
        rd_color <= attr_mem[rd_addr];
    end

endmodule

// ==== source/hires_phase_gen.sv ====
`timescale 1ns/10ps

interface timing_if;
    logic [3:0] dot_rising;
    logic       clk_phi;
    logic       phase_start_dav;
    logic       phase_start_pl;
    logic       phase_start_10;
    logic [6:0] cycle_num;
    logic [3:0] raster_line;
    logic [2:0] hires_cycle_bit;
    logic       main_border;
    logic       vborder;

    modport gen (
        output dot_rising, clk_phi, phase_start_dav, phase_start_pl, phase_start_10,
        output cycle_num, raster_line, hires_cycle_bit, main_border, vborder
    );

    modport sink (
        input dot_rising, clk_phi, phase_start_dav, phase_start_pl, phase_start_10,
        input cycle_num, raster_line, hires_cycle_bit, main_border, vborder
    );
endinterface

module hires_phase_gen import hires_pkg::*; (
    input  logic  clk_dot4x,
    input  logic  arst_n,
    timing_if.gen tim
);

    logic [4:0] tick;
    logic [6:0] cycle_ctr;
    logic [3:0] raster_ctr;
    logic       end_of_cycle;
    logic       end_of_line;

    assign end_of_cycle = (tick == 5'd31);
    assign end_of_line = end_of_cycle && (cycle_ctr == 7'(cycles_per_line - 1));

    always_ff @(posedge clk_dot4x or negedge arst_n) begin
        if (!arst_n) begin
            tick <= '0;
            cycle_ctr <= '0;
            raster_ctr <= '0;
        end else begin
            tick <= tick + 5'd1;
            if (end_of_line) begin
                cycle_ctr <= '0;
                if (raster_ctr == 4'(lines_per_frame - 1)) begin
                    raster_ctr <= '0;
                end else begin
                    raster_ctr <= raster_ctr + 4'd1;
                end
            end else if (end_of_cycle) begin
                cycle_ctr <= cycle_ctr + 7'd1;
            end
        end
    end

    // strobes are registered decodes and each one trails the tick count by one
    always_ff @(posedge clk_dot4x or negedge arst_n) begin
        if (!arst_n) begin
            tim.dot_rising <= '0;
            tim.clk_phi <= 1'b0;
            tim.phase_start_dav <= 1'b0;
            tim.phase_start_10 <= 1'b0;
            tim.phase_start_pl <= 1'b0;
            tim.hires_cycle_bit <= '0;
        end else begin
            tim.dot_rising <= 4'b0001 << tick[1:0];
            // phi low for the first half of the cycle
            tim.clk_phi <= tick[4];
            tim.phase_start_dav <= (tick == 5'd0);
            tim.phase_start_10 <= (tick == 5'd10);
            tim.phase_start_pl <= (tick == 5'd16);
            // steps in the same tick that dot_rising[1] or dot_rising[3] rises
            if (tick[0]) begin
                tim.hires_cycle_bit <= tim.hires_cycle_bit + 3'd1;
            end
        end
    end

    assign tim.cycle_num = cycle_ctr;
    assign tim.raster_line = raster_ctr;
    assign tim.main_border = (cycle_ctr < first_visible_cycle) ||
                             (cycle_ctr > last_visible_cycle);
    assign tim.vborder = (raster_ctr < first_visible_line) ||
                         (raster_ctr > last_visible_line);

endmodule

// ==== source/hires_pkg.sv ====
package hires_pkg;

    // frame geometry, kept short so a whole frame simulates quickly
    localparam int cycles_per_line = 65;
    localparam int lines_per_frame = 12;

    // visible window in phi cycles and raster lines
    localparam int first_visible_cycle = 15;
    localparam int last_visible_cycle = 54;
    localparam int first_visible_line = 2;
    localparam int last_visible_line = 9;

    // one pixel byte and one attribute byte per cell
    localparam int cols_per_row = 40;

    // video RAM plane depth
    localparam int ram_depth = 1024;

    // phase_start_10 stages between fetch and the pl stage
    localparam int seq_delay_stages = 5;

    // blink counter bit that gates blinking characters
    localparam int blink_freq_bit = 5;

    // attribute flag positions within the attribute byte
    localparam int attr_blnk_bit = 4;
    localparam int attr_undr_bit = 5;
    localparam int attr_rvrs_bit = 6;

    localparam logic [1:0] mode_text = 2'b00;
    localparam logic [1:0] mode_bitmap = 2'b01;
    localparam logic [1:0] mode_packed16 = 2'b10;
    localparam logic [1:0] mode_packed4 = 2'b11;

    // text and bitmap view of the attribute byte
    // flags[7] is spare, the others sit at the attr_*_bit positions
    typedef struct packed {
        logic [7:4] flags;
        logic [3:0] color;
    } hires_attr_t;

    // packed modes use the same byte as the upper half of a pixel pair
    typedef union packed {
        hires_attr_t attr;
        logic [7:0]  pair_hi;
    } hires_attr_u;

endpackage
